/* axil_link_regs.sv */
// AXI4-Lite register block, holds period and tx word, starts frames and collects link status
module axil_link_regs import serial_link_pkg::*; #(
	parameter bit_period_t PERIOD_RESET = default_period
) (
	input  logic        clk_sys,
	input  logic        rst_n,
	// write channels
	input  logic        awvalid,
	output logic        awready,
	input  reg_addr_t   awaddr,
	input  logic        wvalid,
	output logic        wready,
	input  logic [31:0] wdata,
	output logic        bvalid,
	input  logic        bready,
	output logic [1:0]  bresp,
	// read channels
	input  logic        arvalid,
	output logic        arready,
	input  reg_addr_t   araddr,
	output logic        rvalid,
	input  logic        rready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	// engines
	output logic        tx_fire,
	output frame_word_t tx_word,
	input  logic        tx_done,
	output bit_period_t bit_period,
	input  rx_result_t  rx_result
);

	logic         wr_en;
	logic         rd_en;
	logic         ctrl_start;
	logic         status_wr;
	logic         rxdata_rd;
	link_status_t clr_mask;
	link_status_t status;
	frame_word_t  rx_word;
	logic [31:0]  rd_mux;

	assign wr_en      = awready && awvalid && wvalid;
	assign rd_en      = arready && arvalid;
	assign ctrl_start = wr_en && (awaddr == addr_ctrl) && wdata[0];
	assign status_wr  = wr_en && (awaddr == addr_status);
	assign rxdata_rd  = rd_en && (araddr == addr_rxdata);
	assign clr_mask   = link_status_t'(wdata[4:0]);

	assign bresp = axi_resp_okay;
	assign rresp = axi_resp_okay;

	// --------------------
	// write channel
	// --------------------
	// address and data taken together, one beat per response
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			awready <= awvalid && wvalid && !bvalid && !awready;
			wready  <= awvalid && wvalid && !bvalid && !awready;
			if (wr_en)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			bit_period <= PERIOD_RESET;
			tx_fire    <= 1'b0;
		end else begin
			if (wr_en && awaddr == addr_period)
				bit_period <= wdata[19:0];
			tx_fire <= ctrl_start && !status.tx_busy;
		end
	end

	// word is frozen while a frame is on the line
	always_ff @(posedge clk_sys) begin
		if (wr_en && awaddr == addr_txdata && !status.tx_busy)
			tx_word <= wdata[15:0];
		if (rx_result.valid)
			rx_word <= rx_result.word;
	end

	// --------------------
	// status
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			status <= '0;
		end else begin
			if (tx_fire)
				status.tx_busy <= 1'b1;
			else if (tx_done)
				status.tx_busy <= 1'b0;

			// clears first so a new event in the same cycle wins
			if (rxdata_rd)
				status.rx_valid <= 1'b0;
			if (status_wr && clr_mask.frame_err)
				status.frame_err <= 1'b0;
			if (status_wr && clr_mask.rx_overrun)
				status.rx_overrun <= 1'b0;
			if (status_wr && clr_mask.tx_rejected)
				status.tx_rejected <= 1'b0;

			if (rx_result.valid) begin
				status.rx_valid <= 1'b1;
				if (status.rx_valid && !rxdata_rd)
					status.rx_overrun <= 1'b1;
				if (!rx_result.stop_ok)
					status.frame_err <= 1'b1;
			end
			if (ctrl_start && status.tx_busy)
				status.tx_rejected <= 1'b1;
		end
	end

	// --------------------
	// read channel
	// --------------------
	always_comb begin
		case (araddr)
			addr_period: rd_mux = {12'd0, bit_period};
			addr_txdata: rd_mux = {16'd0, tx_word};
			addr_rxdata: rd_mux = {16'd0, rx_word};
			addr_status: rd_mux = {27'd0, status};
			default:     rd_mux = 32'd0;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= arvalid && !rvalid && !arready;
			if (rd_en)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rd_en)
			rdata <= rd_mux;
	end

	// --------------------
	// checks
	// --------------------
	a_bvalid_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		bvalid && !bready |=> bvalid);

	a_rdata_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

/* frame_rx.sv */
// serial receiver that finds the start bit, samples sixteen data bits mid-bit and checks both stops
module frame_rx import serial_link_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        rx,
	input  bit_period_t bit_period,
	output rx_result_t  rx_result
);

	logic        rx_meta;
	logic        rx_sync;
	logic        rx_prev;
	rx_state_t   state;
	bit_period_t cnt_cycle;
	bit_period_t cnt_limit;
	logic [3:0]  bit_idx;
	logic        sample;
	frame_word_t shift_q;
	logic        stop1_q;
	logic        stop_ok_q;
	logic        valid_q;

	// --------------------
	// input sync
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// half a cell to the start bit middle and full cells after that
	assign cnt_limit = (state == rx_start) ?
		bit_period_t'({1'b0, bit_period[19:1]} - 20'd1) :
		bit_period_t'(bit_period - 20'd1);
	assign sample = (state != rx_idle) && (cnt_cycle == cnt_limit);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt_cycle <= '0;
		end else if (state == rx_idle || sample) begin
			cnt_cycle <= '0;
		end else begin
			cnt_cycle <= cnt_cycle + 20'd1;
		end
	end

	// --------------------
	// frame FSM
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state   <= rx_idle;
			bit_idx <= 4'd15;
		end else begin
			case (state)
				rx_idle: begin
					// falling edge on the line
					if (rx_prev && !rx_sync)
						state <= rx_start;
				end
				rx_start: begin
					if (sample) begin
						if (!rx_sync) begin
							state   <= rx_data;
							bit_idx <= 4'd15;
						end else begin
							// glitch rather than a start bit
							state <= rx_idle;
						end
					end
				end
				rx_data: begin
					if (sample) begin
						if (bit_idx == 4'd0)
							state <= rx_stop1;
						else
							bit_idx <= bit_idx - 4'd1;
					end
				end
				rx_stop1: begin
					if (sample)
						state <= rx_stop2;
				end
				rx_stop2: begin
					if (sample)
						state <= rx_idle;
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// msb arrives first on the data path
	always_ff @(posedge clk_sys) begin
		if (state == rx_data && sample)
			shift_q <= {shift_q[14:0], rx_sync};
		if (state == rx_stop1 && sample)
			stop1_q <= rx_sync;
		if (state == rx_stop2 && sample)
			stop_ok_q <= stop1_q && rx_sync;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			valid_q <= 1'b0;
		else
			valid_q <= (state == rx_stop2) && sample;
	end

	assign rx_result = '{word: shift_q, valid: valid_q, stop_ok: stop_ok_q};

	// --------------------
	// checks
	// --------------------
	a_valid_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rx_result.valid |=> !rx_result.valid);

endmodule

/* frame_tx.sv */
// serial transmitter that frames one 16-bit word per tx_fire pulse from the register block
module frame_tx import serial_link_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        tx_fire,
	input  frame_word_t tx_word,
	input  bit_period_t bit_period,
	output logic        tx,
	output logic        tx_done
);

	tx_state_t   state;
	bit_period_t cnt_cycle;
	logic [3:0]  bit_idx;
	logic        sending;
	logic        cell_end;

	// the done port hides the state literal of the same name
	assign sending  = (state != tx_idle) && (state != serial_link_pkg::tx_done);
	assign cell_end = sending && (cnt_cycle == bit_period_t'(bit_period - 20'd1));

	// --------------------
	// bit cell timing
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt_cycle <= '0;
		end else if (!sending || cell_end) begin
			cnt_cycle <= '0;
		end else begin
			cnt_cycle <= cnt_cycle + 20'd1;
		end
	end

	// --------------------
	// main FSM
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state   <= tx_idle;
			bit_idx <= 4'd15;
		end else begin
			case (state)
				tx_idle: begin
					if (tx_fire) begin
						state   <= tx_start;
						bit_idx <= 4'd15;
					end
				end
				tx_start: begin
					if (cell_end)
						state <= tx_data;
				end
				tx_data: begin
					// msb first as the index walks down to 0
					if (cell_end) begin
						if (bit_idx == 4'd0)
							state <= tx_stop1;
						else
							bit_idx <= bit_idx - 4'd1;
					end
				end
				tx_stop1: begin
					if (cell_end)
						state <= tx_stop2;
				end
				tx_stop2: begin
					if (cell_end)
						state <= serial_link_pkg::tx_done;
				end
				serial_link_pkg::tx_done: state <= tx_idle;
				default: state <= tx_idle;
			endcase
		end
	end

	// line idles high like the stop cells
	always_comb begin
		case (state)
			tx_start: tx = 1'b0;
			tx_data:  tx = tx_word[bit_idx];
			default:  tx = 1'b1;
		endcase
	end

	assign tx_done = (state == serial_link_pkg::tx_done);

	// --------------------
	// checks
	// --------------------
	a_fire_when_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		tx_fire |-> state == tx_idle);

	// line drops after fire and stays low for the whole start cell
	a_start_low: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(tx_fire || (state == tx_start && !cell_end)) |=> !tx);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the serial link testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_serial_link -f sim.f \
	|| { echo "build failed"; exit 1; }

./obj_dir/Vtb_serial_link 2>&1 | tee sim.log

grep -q "Simulation FAILED" sim.log && { echo "run failed"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "no pass result in log"; exit 1; }
exit 0

/* serial_link_pkg.sv */
// shared widths, register map, FSM states and status types for the serial link RTL and testbench
package serial_link_pkg;

	// --------------------
	// widths
	// --------------------
	localparam int frame_bits  = 16;
	localparam int period_bits = 20;
	localparam int addr_bits   = 5;

	// start, sixteen data and two stop cells
	localparam int frame_cells = 19;

	typedef logic [frame_bits-1:0]  frame_word_t;
	typedef logic [period_bits-1:0] bit_period_t;
	typedef logic [addr_bits-1:0]   reg_addr_t;

	// clk_sys cycles per bit out of reset
	localparam bit_period_t default_period = 20'd16;

	// --------------------
	// register map
	// --------------------
	// bit 0 written as 1 starts a frame
	localparam reg_addr_t addr_ctrl   = 5'h00;
	localparam reg_addr_t addr_period = 5'h04;
	localparam reg_addr_t addr_txdata = 5'h08;
	// read clears rx_valid
	localparam reg_addr_t addr_rxdata = 5'h0C;
	// write 1s to clear sticky bits
	localparam reg_addr_t addr_status = 5'h10;

	localparam logic [1:0] axi_resp_okay = 2'b00;

	// status word, tx_busy lands in bit 0
	typedef struct packed {
		logic tx_rejected;
		logic rx_overrun;
		logic frame_err;
		logic rx_valid;
		logic tx_busy;
	} link_status_t;

	// --------------------
	// engine states
	// --------------------
	typedef enum logic [2:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_stop1,
		tx_stop2,
		tx_done
	} tx_state_t;

	typedef enum logic [2:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop1,
		rx_stop2
	} rx_state_t;

	// one received frame, valid is a single-cycle pulse
	typedef struct packed {
		frame_word_t word;
		logic        valid;
		logic        stop_ok;
	} rx_result_t;

endpackage

/* serial_link_top.sv */
// serial link endpoint top, joins the AXI4-Lite register block to the tx and rx engines
module serial_link_top import serial_link_pkg::*; #(
	parameter bit_period_t PERIOD_RESET = default_period
) (
	input  logic        clk_sys,
	input  logic        rst_n,
	// serial pins
	input  logic        rx,
	output logic        tx,
	// AXI4-Lite
	input  logic        awvalid,
	output logic        awready,
	input  reg_addr_t   awaddr,
	input  logic        wvalid,
	output logic        wready,
	input  logic [31:0] wdata,
	output logic        bvalid,
	input  logic        bready,
	output logic [1:0]  bresp,
	input  logic        arvalid,
	output logic        arready,
	input  reg_addr_t   araddr,
	output logic        rvalid,
	input  logic        rready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp
);

	logic        tx_fire;
	frame_word_t tx_word;
	logic        tx_done;
	bit_period_t bit_period;
	rx_result_t  rx_result;

	axil_link_regs #(
		.PERIOD_RESET(PERIOD_RESET)
	) axil_link_regs_inst (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.awvalid    (awvalid),
		.awready    (awready),
		.awaddr     (awaddr),
		.wvalid     (wvalid),
		.wready     (wready),
		.wdata      (wdata),
		.bvalid     (bvalid),
		.bready     (bready),
		.bresp      (bresp),
		.arvalid    (arvalid),
		.arready    (arready),
		.araddr     (araddr),
		.rvalid     (rvalid),
		.rready     (rready),
		.rdata      (rdata),
		.rresp      (rresp),
		.tx_fire    (tx_fire),
		.tx_word    (tx_word),
		.tx_done    (tx_done),
		.bit_period (bit_period),
		.rx_result  (rx_result)
	);

	frame_tx frame_tx_inst (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.tx_fire    (tx_fire),
		.tx_word    (tx_word),
		.bit_period (bit_period),
		.tx         (tx),
		.tx_done    (tx_done)
	);

	frame_rx frame_rx_inst (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.rx         (rx),
		.bit_period (bit_period),
		.rx_result  (rx_result)
	);

endmodule

/* sim.f */
serial_link_pkg.sv
frame_tx.sv
frame_rx.sv
axil_link_regs.sv
serial_link_top.sv
tb_serial_link.sv

/* tb_serial_link.sv */
// testbench for the serial link endpoint that drives AXI4-Lite and checks frames against a model
module tb_serial_link import serial_link_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam bit_period_t period_reset = 20'd16;
	localparam int max_period = 40;
	// 20 loopback, timing, reject, frame error and two overrun frames
	localparam int frame_count = 25;
	localparam int watchdog_cycles = frame_count * (frame_cells * max_period + 100) + 2000;
	localparam int max_polls = 400;

	logic        clk_sys;
	logic        rst_n;
	logic        rx;
	logic        tx;
	logic        awvalid;
	logic        awready;
	reg_addr_t   awaddr;
	logic        wvalid;
	logic        wready;
	logic [31:0] wdata;
	logic        bvalid;
	logic        bready;
	logic [1:0]  bresp;
	logic        arvalid;
	logic        arready;
	reg_addr_t   araddr;
	logic        rvalid;
	logic        rready;
	logic [31:0] rdata;
	logic [1:0]  rresp;

	logic        rx_from_tx;
	logic        bb_line;
	logic [15:0] lfsr_state;
	int          errors;
	int          checks;

	// rx comes from the DUT tx in loopback or from the bit-bang driver
	assign rx = rx_from_tx ? tx : bb_line;

	serial_link_top #(
		.PERIOD_RESET(period_reset)
	) serial_link_top_inst (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.rx      (rx),
		.tx      (tx),
		.awvalid (awvalid),
		.awready (awready),
		.awaddr  (awaddr),
		.wvalid  (wvalid),
		.wready  (wready),
		.wdata   (wdata),
		.bvalid  (bvalid),
		.bready  (bready),
		.bresp   (bresp),
		.arvalid (arvalid),
		.arready (arready),
		.araddr  (araddr),
		.rvalid  (rvalid),
		.rready  (rready),
		.rdata   (rdata),
		.rresp   (rresp)
	);

	always #50 clk_sys = ~clk_sys;

	// --------------------
	// helpers
	// --------------------
	// taps 16 14 13 11
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_step()};
		return v;
	endfunction

	// start cell first, word msb first, then both stops
	function automatic logic [18:0] model_frame(input frame_word_t word, input logic stop1,
		input logic stop2);
		return {1'b0, word, stop1, stop2};
	endfunction

	function automatic logic [31:0] status_word(input logic busy, input logic rxv,
		input logic ferr, input logic ovr, input logic rej);
		link_status_t s;
		s.tx_busy     = busy;
		s.rx_valid    = rxv;
		s.frame_err   = ferr;
		s.rx_overrun  = ovr;
		s.tx_rejected = rej;
		return {27'd0, s};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic axil_write(input reg_addr_t addr, input logic [31:0] data);
		#1;
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		do @(posedge clk_sys); while (!awready);
		check_value($sformatf("wready with awready %h", addr), 32'd1, {31'd0, wready});
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		do @(posedge clk_sys); while (!bvalid);
		check_value($sformatf("write response %h", addr), {30'd0, axi_resp_okay},
			{30'd0, bresp});
	endtask

	task automatic axil_read(input reg_addr_t addr, output logic [31:0] data);
		#1;
		araddr  = addr;
		arvalid = 1'b1;
		do @(posedge clk_sys); while (!arready);
		#1;
		arvalid = 1'b0;
		do @(posedge clk_sys); while (!rvalid);
		data = rdata;
		check_value($sformatf("read response %h", addr), {30'd0, axi_resp_okay},
			{30'd0, rresp});
	endtask

	task automatic wait_status(input logic [31:0] mask, input logic [31:0] value,
		input string what, output logic [31:0] st);
		int polls;
		polls = 0;
		do begin
			axil_read(addr_status, st);
			polls++;
		end while ((st & mask) != value && polls < max_polls);
		assert ((st & mask) == value) else begin
			$display("%s: status stuck at %h after %0d reads", what, st, polls);
			errors++;
		end
	endtask

	// one cell per period driven just after the clock edge
	task automatic drive_frame(input frame_word_t word, input logic stop1, input logic stop2,
		input bit_period_t period);
		logic [18:0] frame;
		frame = model_frame(word, stop1, stop2);
		for (int i = 0; i < frame_cells; i++) begin
			#1 bb_line = frame[18-i];
			repeat (period) @(posedge clk_sys);
		end
	endtask

	// --------------------
	// tests
	// --------------------
	task automatic check_regs();
		logic [31:0] data;
		logic [31:0] val;
		axil_read(addr_period, data);
		check_value("period after reset", {12'd0, period_reset}, data);
		axil_read(addr_status, data);
		check_value("status after reset", 32'd0, data);
		val = rand_bits(20);
		axil_write(addr_period, val);
		axil_read(addr_period, data);
		check_value("period readback", val, data);
		val = rand_bits(16);
		axil_write(addr_txdata, val);
		axil_read(addr_txdata, data);
		check_value("txdata readback", val, data);
		for (int a = 5'h14; a <= 5'h1C; a += 4) begin
			axil_read(reg_addr_t'(a), data);
			check_value($sformatf("unmapped %h", a), 32'd0, data);
		end
	endtask

	task automatic run_loopback(input int count);
		frame_word_t word;
		bit_period_t period;
		logic [31:0] st;
		logic [31:0] data;
		rx_from_tx = 1'b1;
		for (int n = 0; n < count; n++) begin
			word   = frame_word_t'(rand_bits(16));
			period = bit_period_t'(8 + rand_bits(6) % 33);
			axil_write(addr_period, {12'd0, period});
			axil_write(addr_txdata, {16'd0, word});
			axil_write(addr_ctrl, 32'd1);
			wait_status(status_word(1'b1, 1'b1, 1'b0, 1'b0, 1'b0),
				status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b0), "loopback frame", st);
			axil_read(addr_rxdata, data);
			check_value($sformatf("loopback word %0d", n), {16'd0, word}, data);
			axil_read(addr_status, st);
			check_value($sformatf("loopback status %0d", n), 32'd0, st);
		end
	endtask

	task automatic check_frame_timing();
		frame_word_t word;
		bit_period_t period;
		logic [18:0] frame;
		logic [31:0] st;
		logic [31:0] data;
		time         t0;
		int          cycles;
		word   = frame_word_t'(rand_bits(16));
		period = bit_period_t'(8 + rand_bits(6) % 33);
		frame  = model_frame(word, 1'b1, 1'b1);
		rx_from_tx = 1'b1;
		axil_write(addr_period, {12'd0, period});
		axil_write(addr_txdata, {16'd0, word});
		axil_write(addr_ctrl, 32'd1);
		// tx_fire was high in the cycle before the write response returned
		t0 = $time;
		@(posedge clk_sys);
		check_value("tx low after fire", 32'd0, {31'd0, tx});
		repeat (period / 2) @(posedge clk_sys);
		for (int i = 0; i < frame_cells; i++) begin
			if (i > 0)
				repeat (period) @(posedge clk_sys);
			check_value($sformatf("tx cell %0d", i), {31'd0, frame[18-i]}, {31'd0, tx});
		end
		wait_status(status_word(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), 32'd0, "tx busy clear", st);
		cycles = int'(($time - t0) / 100);
		assert (cycles <= frame_cells * int'(period) + 10) else begin
			$display("tx_busy took %0d cycles to clear at period %0d", cycles, period);
			errors++;
		end
		wait_status(status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b0),
			status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b0), "timing frame received", st);
		axil_read(addr_rxdata, data);
		check_value("timing frame word", {16'd0, word}, data);
	endtask

	task automatic check_tx_reject();
		frame_word_t word;
		logic [31:0] st;
		logic [31:0] data;
		word = frame_word_t'(rand_bits(16));
		rx_from_tx = 1'b1;
		axil_write(addr_period, 32'd16);
		axil_write(addr_txdata, {16'd0, word});
		axil_write(addr_ctrl, 32'd1);
		axil_write(addr_ctrl, 32'd1);
		wait_status(status_word(1'b1, 1'b1, 1'b0, 1'b0, 1'b0),
			status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b0), "rejected fire frame", st);
		check_value("reject status", status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b1), st);
		axil_read(addr_rxdata, data);
		check_value("reject frame word", {16'd0, word}, data);
		axil_write(addr_status, 32'h1F);
		axil_read(addr_status, st);
		check_value("reject cleared", 32'd0, st);
	endtask

	task automatic check_frame_error();
		frame_word_t word;
		logic [31:0] st;
		logic [31:0] data;
		word = frame_word_t'(rand_bits(16));
		rx_from_tx = 1'b0;
		axil_write(addr_period, 32'd16);
		drive_frame(word, 1'b0, 1'b1, 20'd16);
		wait_status(status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b0),
			status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b0), "bad stop frame", st);
		check_value("frame error status", status_word(1'b0, 1'b1, 1'b1, 1'b0, 1'b0), st);
		axil_write(addr_status, 32'h1F);
		axil_read(addr_status, st);
		check_value("frame error cleared", status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b0), st);
		axil_read(addr_rxdata, data);
		check_value("bad stop word", {16'd0, word}, data);
	endtask

	task automatic check_overrun();
		frame_word_t first;
		frame_word_t second;
		logic [31:0] st;
		logic [31:0] data;
		first  = frame_word_t'(rand_bits(16));
		second = frame_word_t'(rand_bits(16));
		rx_from_tx = 1'b0;
		drive_frame(first, 1'b1, 1'b1, 20'd16);
		drive_frame(second, 1'b1, 1'b1, 20'd16);
		wait_status(status_word(1'b0, 1'b1, 1'b0, 1'b1, 1'b0),
			status_word(1'b0, 1'b1, 1'b0, 1'b1, 1'b0), "second frame", st);
		check_value("overrun status", status_word(1'b0, 1'b1, 1'b0, 1'b1, 1'b0), st);
		axil_read(addr_rxdata, data);
		check_value("overrun word", {16'd0, second}, data);
		axil_write(addr_status, 32'h1F);
		axil_read(addr_status, st);
		check_value("overrun cleared", 32'd0, st);
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		clk_sys    = 1'b0;
		rst_n      = 1'b0;
		awvalid    = 1'b0;
		awaddr     = '0;
		wvalid     = 1'b0;
		wdata      = '0;
		bready     = 1'b1;
		arvalid    = 1'b0;
		araddr     = '0;
		rready     = 1'b1;
		bb_line    = 1'b1;
		rx_from_tx = 1'b1;
		lfsr_state = 16'd66;
		errors     = 0;
		checks     = 0;
		repeat (5) @(posedge clk_sys);
		#1 rst_n = 1'b1;
		@(posedge clk_sys);

		check_regs();
		run_loopback(20);
		check_frame_timing();
		check_tx_reject();
		check_frame_error();
		check_overrun();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial begin : watchdog
		#(watchdog_cycles * 100);
		$display("timeout, tests did not finish within %0d clock cycles", watchdog_cycles);
		$display("Simulation FAILED");
		$finish;
	end

endmodule
